//--- verilog/wisc_params.svh
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// Data and instruction width
`define WORD_W 16

`define REG_AW 3
`define IMEM_AW 8
`define DMEM_AW 8

`endif

//--- verilog/wiscPkg.sv
package wiscPkg;

    // Encodings run in order from 5'b00000
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000, OP_NOP, OP_SIIC, OP_RTI,
        OP_J, OP_JR, OP_JAL, OP_JALR,
        OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
        OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
        OP_ST, OP_LD, OP_SLBI, OP_STU,
        OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
        OP_LBI, OP_BTR, OP_RSHIFT, OP_RARITH,
        OP_SEQ, OP_SLT, OP_SLE, OP_SCO
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUBR, ALU_XOR, ALU_ANDN,
        ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
        ALU_EQ, ALU_LT, ALU_LE, ALU_CO,
        ALU_BTR, ALU_PASSB, ALU_SLBI
    } aluOpE;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSrcE;

    // Rd of R-format, Rd of I-format, Rs, link register
    typedef enum logic [1:0] {DST_RD_R, DST_RD_I, DST_RS, DST_R7} regDstE;

    typedef enum logic [2:0] {IMM_S5, IMM_Z5, IMM_S8, IMM_Z8, IMM_S11} immKindE;

    typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} brCondE;

endpackage

//--- verilog/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf import wiscPkg::*; ();
    aluOpE   aluOp;
    logic    bUsesImm;
    immKindE immKind;
    brCondE  brCond;
    logic    jump;
    logic    jumpReg;       // Target from Rs instead of PC
    logic    regWe;
    regDstE  regDst;
    logic    memWe;
    logic    memRe;
    wbSrcE   wbSrc;
    logic    halt;
    logic    illegal;

    modport dec (output aluOp, bUsesImm, immKind, brCond, jump, jumpReg, regWe, regDst,
                 memWe, memRe, wbSrc, halt, illegal);
    modport exe (input aluOp, bUsesImm, immKind, brCond, jump, jumpReg);
    modport wb  (input regWe, regDst, memWe, memRe, wbSrc, halt, illegal);

endinterface

//--- verilog/fetch.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module fetch (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    input  logic                stop,
    input  logic [`IMEM_AW-1:0] nextPc,
    input  logic                progWe,
    input  logic [`IMEM_AW-1:0] progAddr,
    input  logic [`WORD_W-1:0]  progData,
    output logic [`IMEM_AW-1:0] pc,
    output logic [`WORD_W-1:0]  instr
);

    logic [`WORD_W-1:0] imem [0:(1 << `IMEM_AW)-1];

    always_ff @(posedge clk) begin
        if (!run && progWe) begin
            imem[progAddr] <= progData;     // Program load only while stopped
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run && !stop) begin
            pc <= nextPc;
        end
    end

    assign instr = imem[pc];        // Async read

endmodule

//--- verilog/control.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module control import wiscPkg::*; (
    input  logic [`WORD_W-1:0] instr,
    ctrlIf.dec                 ctrl
);

    opcodeE     op;
    logic [1:0] sel;
    aluOpE      arithOp;
    aluOpE      shiftOp;

    assign op  = opcodeE'(instr[15:11]);
    // Immediate forms carry the selector in the opcode low bits
    assign sel = (op == OP_RARITH || op == OP_RSHIFT) ? instr[1:0] : instr[12:11];

    always_comb begin
        case (sel)
            2'b00: begin
                arithOp = ALU_ADD;
                shiftOp = ALU_ROL;
            end
            2'b01: begin
                arithOp = ALU_SUBR;     // B minus A
                shiftOp = ALU_SLL;
            end
            2'b10: begin
                arithOp = ALU_XOR;
                shiftOp = ALU_ROR;
            end
            default: begin
                arithOp = ALU_ANDN;
                shiftOp = ALU_SRL;
            end
        endcase
    end

    always_comb begin
        ctrl.aluOp    = ALU_ADD;
        ctrl.bUsesImm = 1'b0;
        ctrl.immKind  = IMM_S5;
        ctrl.brCond   = BR_NONE;
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.regWe    = 1'b0;
        ctrl.regDst   = DST_RD_R;
        ctrl.memWe    = 1'b0;
        ctrl.memRe    = 1'b0;
        ctrl.wbSrc    = WB_ALU;
        ctrl.halt     = 1'b0;
        ctrl.illegal  = 1'b0;
        case (op)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP: ctrl.halt = 1'b0;
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                ctrl.aluOp    = arithOp;
                ctrl.bUsesImm = 1'b1;
                ctrl.immKind  = instr[12] ? IMM_Z5 : IMM_S5;    // Logic ops zero-extend
                ctrl.regWe    = 1'b1;
                ctrl.regDst   = DST_RD_I;
            end
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                ctrl.aluOp    = shiftOp;
                ctrl.bUsesImm = 1'b1;
                ctrl.immKind  = IMM_Z5;
                ctrl.regWe    = 1'b1;
                ctrl.regDst   = DST_RD_I;
            end
            OP_RARITH, OP_RSHIFT: begin
                ctrl.aluOp = (op == OP_RARITH) ? arithOp : shiftOp;
                ctrl.regWe = 1'b1;
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BTR: begin
                case (op)
                    OP_SEQ:  ctrl.aluOp = ALU_EQ;
                    OP_SLT:  ctrl.aluOp = ALU_LT;
                    OP_SLE:  ctrl.aluOp = ALU_LE;
                    OP_SCO:  ctrl.aluOp = ALU_CO;
                    default: ctrl.aluOp = ALU_BTR;
                endcase
                ctrl.regWe = 1'b1;
            end
            OP_LBI, OP_SLBI: begin
                ctrl.aluOp    = (op == OP_LBI) ? ALU_PASSB : ALU_SLBI;
                ctrl.bUsesImm = 1'b1;
                ctrl.immKind  = (op == OP_LBI) ? IMM_S8 : IMM_Z8;
                ctrl.regWe    = 1'b1;
                ctrl.regDst   = DST_RS;
            end
            OP_ST, OP_LD, OP_STU: begin
                ctrl.bUsesImm = 1'b1;           // Address is Rs + sext(imm5)
                ctrl.memWe    = (op != OP_LD);
                ctrl.memRe    = (op == OP_LD);
                ctrl.regWe    = (op != OP_ST);
                ctrl.regDst   = (op == OP_LD) ? DST_RD_I : DST_RS;
                ctrl.wbSrc    = (op == OP_LD) ? WB_MEM : WB_ALU;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.immKind = IMM_S8;
                case (instr[12:11])
                    2'b00:   ctrl.brCond = BR_EQZ;
                    2'b01:   ctrl.brCond = BR_NEZ;
                    2'b10:   ctrl.brCond = BR_LTZ;
                    default: ctrl.brCond = BR_GEZ;
                endcase
            end
            OP_J, OP_JR, OP_JAL, OP_JALR: begin
                ctrl.jump    = 1'b1;
                ctrl.jumpReg = instr[11];
                ctrl.immKind = instr[11] ? IMM_S8 : IMM_S11;
                ctrl.regWe   = instr[12];       // JAL and JALR link
                ctrl.regDst  = DST_R7;
                ctrl.wbSrc   = WB_LINK;
            end
            OP_SIIC, OP_RTI: ctrl.illegal = 1'b1;  // No exception support
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REG_AW-1:0] rdAddrA,
    input  logic [`REG_AW-1:0] rdAddrB,
    output logic [`WORD_W-1:0] rdA,
    output logic [`WORD_W-1:0] rdB,
    input  logic               wrEn,
    input  logic [`REG_AW-1:0] wrAddr,
    input  logic [`WORD_W-1:0] wrData
);

    logic [`WORD_W-1:0] regs [0:(1 << `REG_AW)-1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << `REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see the old value until the edge
    assign rdA = regs[rdAddrA];
    assign rdB = regs[rdAddrB];

endmodule

//--- verilog/execute.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module execute import wiscPkg::*; (
    input  logic [`WORD_W-1:0]  instr,
    input  logic [`IMEM_AW-1:0] pc,
    input  logic [`WORD_W-1:0]  rdA,
    input  logic [`WORD_W-1:0]  rdB,
    ctrlIf.exe                  ctrl,
    output logic [`WORD_W-1:0]  aluResult,
    output logic [`WORD_W-1:0]  storeData,
    output logic [`IMEM_AW-1:0] nextPc
);

    logic [`WORD_W-1:0]   imm;
    logic [`WORD_W-1:0]   opB;
    logic [`WORD_W-1:0]   rev;
    logic [`WORD_W:0]     sum;
    logic [2*`WORD_W-1:0] rolFull;
    logic [2*`WORD_W-1:0] rorFull;
    logic [3:0]           amt;
    logic [`IMEM_AW-1:0]  pcInc;
    logic                 taken;

    always_comb begin
        case (ctrl.immKind)
            IMM_S5:  imm = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
            IMM_Z5:  imm = {{(`WORD_W-5){1'b0}}, instr[4:0]};
            IMM_S8:  imm = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
            IMM_Z8:  imm = {{(`WORD_W-8){1'b0}}, instr[7:0]};
            default: imm = {{(`WORD_W-11){instr[10]}}, instr[10:0]};
        endcase
    end

    always_comb begin
        for (int i = 0; i < `WORD_W; i++) begin
            rev[i] = rdA[`WORD_W-1-i];
        end
    end

    assign opB       = ctrl.bUsesImm ? imm : rdB;
    assign amt       = opB[3:0];
    assign sum       = {1'b0, rdA} + {1'b0, opB};
    assign rolFull   = {rdA, rdA} << amt;       // Doubled word gives the wrap
    assign rorFull   = {rdA, rdA} >> amt;
    assign storeData = rdB;                     // Rd of ST and STU sits on port B

    always_comb begin
        case (ctrl.aluOp)
            ALU_SUBR:  aluResult = opB - rdA;
            ALU_XOR:   aluResult = rdA ^ opB;
            ALU_ANDN:  aluResult = rdA & ~opB;
            ALU_ROL:   aluResult = rolFull[2*`WORD_W-1:`WORD_W];
            ALU_SLL:   aluResult = rdA << amt;
            ALU_ROR:   aluResult = rorFull[`WORD_W-1:0];
            ALU_SRL:   aluResult = rdA >> amt;
            ALU_EQ:    aluResult = {{(`WORD_W-1){1'b0}}, rdA == opB};
            ALU_LT:    aluResult = {{(`WORD_W-1){1'b0}}, $signed(rdA) < $signed(opB)};
            ALU_LE:    aluResult = {{(`WORD_W-1){1'b0}}, $signed(rdA) <= $signed(opB)};
            ALU_CO:    aluResult = {{(`WORD_W-1){1'b0}}, sum[`WORD_W]};
            ALU_BTR:   aluResult = rev;
            ALU_PASSB: aluResult = opB;
            ALU_SLBI:  aluResult = {rdA[`WORD_W-9:0], 8'h00} | opB;
            default:   aluResult = sum[`WORD_W-1:0];
        endcase
    end

    always_comb begin
        case (ctrl.brCond)
            BR_EQZ:  taken = (rdA == '0);
            BR_NEZ:  taken = (rdA != '0);
            BR_LTZ:  taken = rdA[`WORD_W-1];
            BR_GEZ:  taken = !rdA[`WORD_W-1];
            default: taken = 1'b0;
        endcase
    end

    // PC wraps at the instruction memory depth
    assign pcInc = pc + 1'b1;
    assign nextPc = (ctrl.jump && ctrl.jumpReg) ? rdA[`IMEM_AW-1:0] + imm[`IMEM_AW-1:0] :
                    (ctrl.jump || taken)        ? pcInc + imm[`IMEM_AW-1:0] : pcInc;

endmodule

//--- verilog/memWriteback.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module memWriteback import wiscPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    input  logic [`WORD_W-1:0]  instr,
    input  logic [`IMEM_AW-1:0] pc,
    input  logic [`WORD_W-1:0]  aluResult,
    input  logic [`WORD_W-1:0]  storeData,
    ctrlIf.wb                   ctrl,
    output logic                wrEn,
    output logic [`REG_AW-1:0]  wrAddr,
    output logic [`WORD_W-1:0]  wrData,
    output logic                stop,
    output logic                err,
    output logic                traceValid,
    output logic [`IMEM_AW-1:0] tracePc,
    output logic                traceWe,
    output logic [`REG_AW-1:0]  traceReg,
    output logic [`WORD_W-1:0]  traceData,
    output logic                traceMemWe,
    output logic [`DMEM_AW-1:0] traceMemAddr,
    output logic [`WORD_W-1:0]  traceMemData
);

    logic [`WORD_W-1:0]  dmem [0:(1 << `DMEM_AW)-1];
    logic [`DMEM_AW-1:0] memAddr;
    logic [`WORD_W-1:0]  loadData;
    logic [`IMEM_AW-1:0] linkPc;
    logic                commit;
    logic                memWrite;

    assign commit   = run && !stop;
    assign memAddr  = aluResult[`DMEM_AW-1:0];
    assign loadData = ctrl.memRe ? dmem[memAddr] : '0;
    assign linkPc   = pc + 1'b1;
    assign memWrite = commit && ctrl.memWe;
    assign wrEn     = commit && ctrl.regWe;

    always_comb begin
        case (ctrl.regDst)
            DST_RD_R: wrAddr = instr[4:2];
            DST_RD_I: wrAddr = instr[7:5];
            DST_RS:   wrAddr = instr[10:8];     // LBI, SLBI, STU
            default:  wrAddr = `REG_AW'(7);
        endcase
        case (ctrl.wbSrc)
            WB_MEM:  wrData = loadData;
            WB_LINK: wrData = {{(`WORD_W-`IMEM_AW){1'b0}}, linkPc};
            default: wrData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[memAddr] <= storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stop <= 1'b0;
            err  <= 1'b0;
        end else if (commit) begin
            if (ctrl.halt || ctrl.illegal) begin
                stop <= 1'b1;       // Held until reset
            end
            if (ctrl.illegal) begin
                err <= 1'b1;
            end
        end
    end

    assign traceValid   = commit;
    assign tracePc      = pc;
    assign traceWe      = wrEn;
    assign traceReg     = wrAddr;
    assign traceData    = wrData;
    assign traceMemWe   = memWrite;
    assign traceMemAddr = memAddr;
    assign traceMemData = storeData;

endmodule

//--- verilog/wiscCore.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module wiscCore (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    input  logic                progWe,
    input  logic [`IMEM_AW-1:0] progAddr,
    input  logic [`WORD_W-1:0]  progData,
    output logic                halted,
    output logic                err,
    output logic                traceValid,
    output logic [`IMEM_AW-1:0] tracePc,
    output logic                traceWe,
    output logic [`REG_AW-1:0]  traceReg,
    output logic [`WORD_W-1:0]  traceData,
    output logic                traceMemWe,
    output logic [`DMEM_AW-1:0] traceMemAddr,
    output logic [`WORD_W-1:0]  traceMemData
);

    logic [`WORD_W-1:0]  instr;
    logic [`IMEM_AW-1:0] pc;
    logic [`IMEM_AW-1:0] nextPc;
    logic [`WORD_W-1:0]  rdA;
    logic [`WORD_W-1:0]  rdB;
    logic [`WORD_W-1:0]  aluResult;
    logic [`WORD_W-1:0]  storeData;
    logic                wrEn;
    logic [`REG_AW-1:0]  wrAddr;
    logic [`WORD_W-1:0]  wrData;

    ctrlIf ctrl ();

    fetch uFetch (.stop(halted), .*);

    control uControl (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Port A reads Rs, port B reads Rt or the store source
    regFile uRegFile (.rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]), .*);

    execute uExecute (.*);

    memWriteback uMemWriteback (.stop(halted), .*);

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter real PERIOD = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

//--- dv/wiscTb.sv
`timescale 1ns/1ps
`include "wisc_params.svh"

module wiscTb;

    // Loads, resets and runs of all programs, in instructions
    localparam int TOTAL_INSTR = 3400;
    localparam real TIMEOUT_NS = 3.0 * TOTAL_INSTR * 20.0;

    logic clk, rstN, run, progWe;
    logic [`IMEM_AW-1:0] progAddr;
    logic [`WORD_W-1:0] progData;
    logic halted, err, traceValid, traceWe, traceMemWe;
    logic [`IMEM_AW-1:0] tracePc;
    logic [`REG_AW-1:0] traceReg;
    logic [`WORD_W-1:0] traceData, traceMemData;
    logic [`DMEM_AW-1:0] traceMemAddr;

    logic [15:0] prog [256];        // Model copy of instruction memory
    logic [15:0] mRegs [8];
    logic [15:0] mMem [256];
    logic [7:0] mPc, expNextPc, expMemAddr;
    logic mHalted, mErr, expWe, expMemWe, expStop, expIllegal;
    logic [2:0] expReg;
    logic [15:0] expData, expMemData;
    logic [31:0] lfsr;
    int errors, commits;
    logic [4:0] dataOps [20] = '{5'd8, 5'd9, 5'd10, 5'd11, 5'd16, 5'd17, 5'd18, 5'd19,
        5'd20, 5'd21, 5'd22, 5'd23, 5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30, 5'd31};

    tbClock clkGen (.clk(clk));

    wiscCore UUT (.*);

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [15:0] encodeRI(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] encodeRRI(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [2:0] rt, input logic [4:0] low);
        return {op, rs, rt, low};
    endfunction

    function automatic logic [15:0] arith(input logic [1:0] f, input logic [15:0] a,
                                          input logic [15:0] b);
        case (f)
            2'd0: return a + b;
            2'd1: return b - a;     // SUB is B minus A
            2'd2: return a ^ b;
            default: return a & ~b;
        endcase
    endfunction

    function automatic logic [15:0] shift(input logic [1:0] f, input logic [15:0] a,
                                          input logic [3:0] n);
        case (f)
            2'd0: return (a << n) | (a >> (5'd16 - n));
            2'd1: return a << n;
            2'd2: return (a >> n) | (a << (5'd16 - n));
            default: return a >> n;
        endcase
    endfunction

    // Expected effects of the instruction at mPc
    task automatic predict();
        logic [15:0] ins, a, b, s5, z5, s8, z8, s11, addr;
        logic [16:0] sum17;
        logic [4:0] op;
        ins = prog[mPc];
        op = ins[15:11];
        a = mRegs[ins[10:8]];
        b = mRegs[ins[7:5]];
        s5 = {{11{ins[4]}}, ins[4:0]};
        z5 = {11'd0, ins[4:0]};
        s8 = {{8{ins[7]}}, ins[7:0]};
        z8 = {8'd0, ins[7:0]};
        s11 = {{5{ins[10]}}, ins[10:0]};
        addr = a + s5;
        sum17 = {1'b0, a} + {1'b0, b};
        expNextPc = mPc + 8'd1;
        {expWe, expMemWe, expStop, expIllegal} = '0;
        expReg = ins[7:5];
        expData = '0;
        expMemAddr = addr[7:0];
        expMemData = b;
        case (op)
            5'd0: expStop = 1'b1;
            5'd1: ;
            5'd2, 5'd3: expIllegal = 1'b1;
            5'd4, 5'd5, 5'd6, 5'd7: begin
                expNextPc = op[0] ? a[7:0] + s8[7:0] : mPc + 8'd1 + s11[7:0];
                expWe = op[1];
                expReg = 3'd7;
                expData = {8'd0, mPc + 8'd1};
            end
            5'd8, 5'd9, 5'd10, 5'd11: begin
                expWe = 1'b1;
                expData = arith(op[1:0], a, op[1] ? z5 : s5);
            end
            5'd12, 5'd13, 5'd14, 5'd15: begin
                if ((op[1:0] == 2'd0 && a == 16'd0) || (op[1:0] == 2'd1 && a != 16'd0) ||
                    (op[1:0] == 2'd2 && a[15]) || (op[1:0] == 2'd3 && !a[15])) begin
                    expNextPc = mPc + 8'd1 + s8[7:0];
                end
            end
            5'd16: expMemWe = 1'b1;
            5'd17: begin
                expWe = 1'b1;
                expData = mMem[addr[7:0]];
            end
            5'd18, 5'd24: begin
                expWe = 1'b1;
                expReg = ins[10:8];
                expData = (op == 5'd24) ? s8 : ({a[7:0], 8'h00} | z8);
            end
            5'd19: begin
                expMemWe = 1'b1;
                expWe = 1'b1;
                expReg = ins[10:8];
                expData = addr;
            end
            5'd20, 5'd21, 5'd22, 5'd23: begin
                expWe = 1'b1;
                expData = shift(op[1:0], a, ins[3:0]);
            end
            default: begin      // R-format, compares and BTR
                expWe = 1'b1;
                expReg = ins[4:2];
                case (op)
                    5'd25: expData = {<<{a}};
                    5'd26: expData = shift(ins[1:0], a, b[3:0]);
                    5'd27: expData = arith(ins[1:0], a, b);
                    5'd28: expData = {15'd0, a == b};
                    5'd29: expData = {15'd0, $signed(a) < $signed(b)};
                    5'd30: expData = {15'd0, $signed(a) <= $signed(b)};
                    default: expData = {15'd0, sum17[16]};
                endcase
            end
        endcase
    endtask

    always @(negedge clk) begin
        #1 predict();
    end

    always @(posedge clk) begin
        if (rstN && run && !mHalted) begin
            if (expWe) mRegs[expReg] = expData;
            if (expMemWe) mMem[expMemAddr] = expMemData;
            if (expStop || expIllegal) mHalted = 1'b1;
            if (expIllegal) mErr = 1'b1;
            mPc = expNextPc;
            commits++;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) traceValid == (run && !mHalted))
        else begin
            errors++;
            $display("mismatch traceValid exp %h got %h", $sampled(run && !mHalted),
                     $sampled(traceValid));
        end
    assert property (@(posedge clk) disable iff (!rstN) tracePc == mPc)
        else begin
            errors++;
            $display("mismatch tracePc exp %h got %h", $sampled(mPc), $sampled(tracePc));
        end
    assert property (@(posedge clk) disable iff (!rstN) traceValid |-> traceWe == expWe)
        else begin
            errors++;
            $display("mismatch traceWe exp %h got %h", $sampled(expWe), $sampled(traceWe));
        end
    assert property (@(posedge clk) disable iff (!rstN)
                     (traceValid && expWe) |-> (traceReg == expReg && traceData == expData))
        else begin
            errors++;
            $display("mismatch traceReg/traceData exp %h/%h got %h/%h", $sampled(expReg),
                     $sampled(expData), $sampled(traceReg), $sampled(traceData));
        end
    assert property (@(posedge clk) disable iff (!rstN) traceValid |-> traceMemWe == expMemWe)
        else begin
            errors++;
            $display("mismatch traceMemWe exp %h got %h", $sampled(expMemWe),
                     $sampled(traceMemWe));
        end
    assert property (@(posedge clk) disable iff (!rstN) (traceValid && expMemWe) |->
                     (traceMemAddr == expMemAddr && traceMemData == expMemData))
        else begin
            errors++;
            $display("mismatch traceMemAddr/traceMemData exp %h/%h got %h/%h",
                     $sampled(expMemAddr), $sampled(expMemData), $sampled(traceMemAddr),
                     $sampled(traceMemData));
        end
    assert property (@(posedge clk) disable iff (!rstN) halted == mHalted && err == mErr)
        else begin
            errors++;
            $display("mismatch halted/err exp %h/%h got %h/%h", $sampled(mHalted),
                     $sampled(mErr), $sampled(halted), $sampled(err));
        end

    task automatic loadProgram();
        @(negedge clk);
        run = 1'b0;
        for (int i = 0; i < 256; i++) begin
            @(negedge clk);
            progWe = 1'b1;
            progAddr = 8'(i);
            progData = prog[i];
        end
        @(negedge clk);
        progWe = 1'b0;
    endtask

    task automatic resetCore();
        @(negedge clk);
        rstN = 1'b0;
        foreach (mRegs[i]) mRegs[i] = '0;
        mPc = '0;
        mHalted = 1'b0;
        mErr = 1'b0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic runUntilHalt();
        @(negedge clk);
        run = 1'b1;
        while (!halted) @(negedge clk);
        repeat (4) @(negedge clk);      // PC must stay put
        run = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0t with %0d errors, core did not finish", $time, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        lfsr = 32'h7cee_f12f;
        errors = 0;
        commits = 0;
        mPc = '0;
        mHalted = 1'b0;
        mErr = 1'b0;

        // Clear data memory through STU, then halt
        foreach (prog[i]) prog[i] = 16'h0000;
        prog[0] = encodeRI(5'b11000, 3'd1, 8'hFF);
        prog[1] = encodeRI(5'b10010, 3'd4, 8'hFF);
        prog[2] = encodeRRI(5'b10011, 3'd1, 3'd0, 5'd1);
        prog[3] = encodeRRI(5'b11011, 3'd1, 3'd4, {3'd3, 2'b01});
        prog[4] = encodeRI(5'b01101, 3'd3, 8'hFD);
        loadProgram();
        resetCore();
        runUntilHalt();

        foreach (prog[i]) prog[i] = 16'h0800;       // All NOP, wraps the PC
        loadProgram();
        resetCore();
        @(negedge clk);
        run = 1'b1;
        repeat (300) @(negedge clk);
        run = 1'b0;

        repeat (2) begin
            foreach (prog[i]) prog[i] = 16'h0000;
            for (int i = 0; i < 200; i++) begin
                prog[i] = {dataOps[randBits(5) % 20], 11'(randBits(11))};
            end
            loadProgram();
            resetCore();
            runUntilHalt();
        end

        // Branches, jumps, a store and load, then SIIC
        foreach (prog[i]) prog[i] = 16'h0000;
        prog[0] = encodeRI(5'b11000, 3'd1, 8'd5);
        prog[1] = encodeRI(5'b01100, 3'd1, 8'd2);
        prog[2] = encodeRI(5'b01101, 3'd1, 8'd1);
        prog[4] = encodeRI(5'b11000, 3'd2, 8'hFF);
        prog[5] = encodeRI(5'b01110, 3'd2, 8'd1);
        prog[7] = encodeRI(5'b01111, 3'd2, 8'd5);
        prog[8] = {5'b00110, 11'd2};
        prog[9] = {5'b00100, 11'd3};
        prog[11] = encodeRI(5'b00101, 3'd7, 8'd0);
        prog[13] = encodeRI(5'b11000, 3'd3, 8'd20);
        prog[14] = encodeRI(5'b00111, 3'd3, 8'hFC);
        prog[16] = encodeRRI(5'b10000, 3'd1, 3'd2, 5'd3);
        prog[17] = encodeRRI(5'b10001, 3'd1, 3'd4, 5'd3);
        prog[18] = 16'h1000;
        loadProgram();
        resetCore();
        runUntilHalt();
        if (!err) begin
            errors++;
            $display("Illegal opcode did not raise err");
        end

        $display("Summary: %0d errors, %0d instructions committed", errors, commits);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/wiscPkg.sv
verilog/ctrlIf.sv
verilog/fetch.sv
verilog/control.sv
verilog/regFile.sv
verilog/execute.sv
verilog/memWriteback.sv
verilog/wiscCore.sv
dv/tbClock.sv
dv/wiscTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module wiscTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
